// ==== list.f ====
logic/cache_geom_pkg.sv
logic/cache_bus_pkg.sv
logic/dcache_way.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/line_mem_model.sv
dv/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the dcache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module dcache_tb -f list.f -o dcache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== dv/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

    localparam int clk_period  = 100;
    localparam int n_entries   = 19;
    localparam int cycle_limit = 200 * n_entries;

    typedef struct packed {
        logic                       op;       // 1 for a store
        cache_geom_pkg::phys_addr_t addr;
        cache_geom_pkg::byte_strb_t strb;
        cache_bus_pkg::data_word_t  wdata;
        logic                       unc;
        logic                       miss;
        logic                       wb;       // dirty victim leaves
        cache_geom_pkg::phys_addr_t wb_line;
    } entry_t;

    // index 2 at 0x40, index 3 at 0x60, index 8 at 0x100, uncached from 0x8000
    entry_t stim [n_entries] = '{
        '{1'b0, 32'h0000_0040, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_0044, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0},
        '{1'b1, 32'h0000_0048, 4'h6, 32'ha1b2_c3d4, 1'b0, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_0048, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0},
        '{1'b1, 32'h0000_0064, 4'h9, 32'h1122_3344, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_0064, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_0100, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b1, 32'h0000_1104, 4'hf, 32'hcafe_f00d, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_0108, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_2100, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b1, 32'h0000_1100},
        '{1'b0, 32'h0000_0100, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_1104, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_1060, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_2060, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b1, 32'h0000_0060},
        '{1'b0, 32'h0000_0064, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_8010, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 32'h0},
        '{1'b1, 32'h0000_8010, 4'h3, 32'h5566_7788, 1'b1, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_8010, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_0048, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0}
    };

    logic clk;
    logic reset;
    logic req_valid_i;
    logic req_op_i;
    cache_geom_pkg::phys_addr_t req_addr_i;
    cache_geom_pkg::byte_strb_t req_wstrb_i;
    cache_bus_pkg::data_word_t  req_wdata_i;
    logic uncache_i;
    logic addr_ok_o;
    logic data_ok_o;
    cache_bus_pkg::data_word_t  rdata_o;
    logic cache_miss_o;
    logic rd_req_o;
    cache_geom_pkg::phys_addr_t rd_addr_o;
    logic rd_rdy_i;
    logic ret_valid_i;
    cache_bus_pkg::line_data_t  ret_data_i;
    logic wr_req_o;
    cache_geom_pkg::phys_addr_t wr_addr_o;
    cache_bus_pkg::line_data_t  wr_data_o;
    logic wr_rdy_i;
    logic uc_ren_o;
    logic uc_wen_o;
    cache_geom_pkg::phys_addr_t uc_addr_o;
    cache_bus_pkg::data_word_t  uc_wdata_o;
    cache_geom_pkg::byte_strb_t uc_strb_o;
    logic uc_rvalid_i;
    cache_bus_pkg::data_word_t  uc_rdata_i;
    logic uc_bvalid_i;
    int   wb_cnt;
    cache_geom_pkg::phys_addr_t wb_addr;
    cache_bus_pkg::line_data_t  wb_data;

    logic [7:0] shadow [65536];   // expected memory contents
    int err_value = 0;
    int err_other = 0;
    int cycles = 0;

    dcache_top u_dcache_top (.*);

    line_mem_model u_line_mem (
        .clk(clk), .rd_req_i(rd_req_o), .rd_addr_i(rd_addr_o), .rd_rdy_o(rd_rdy_i),
        .ret_valid_o(ret_valid_i), .ret_data_o(ret_data_i),
        .wr_req_i(wr_req_o), .wr_addr_i(wr_addr_o), .wr_data_i(wr_data_o), .wr_rdy_o(wr_rdy_i),
        .uc_ren_i(uc_ren_o), .uc_wen_i(uc_wen_o), .uc_addr_i(uc_addr_o),
        .uc_wdata_i(uc_wdata_o), .uc_strb_i(uc_strb_o), .uc_rvalid_o(uc_rvalid_i),
        .uc_rdata_o(uc_rdata_i), .uc_bvalid_o(uc_bvalid_i),
        .wb_cnt_o(wb_cnt), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic check_word(input string name, input cache_bus_pkg::data_word_t got,
                              input cache_bus_pkg::data_word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_addr(input string name, input cache_geom_pkg::phys_addr_t got,
                              input cache_geom_pkg::phys_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            err_value++;
        end
    endtask

    // little endian word from the expected memory
    function automatic cache_bus_pkg::data_word_t shadow_word(input cache_geom_pkg::phys_addr_t a);
        logic [15:0] b;
        b = {a[15:2], 2'b00};
        return {shadow[b + 16'd3], shadow[b + 16'd2], shadow[b + 16'd1], shadow[b]};
    endfunction

    task automatic shadow_store(input cache_geom_pkg::phys_addr_t a,
                                input cache_geom_pkg::byte_strb_t strb,
                                input cache_bus_pkg::data_word_t wdata);
        logic [15:0] b;
        b = {a[15:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) shadow[b + 16'(k)] = wdata[8*k +: 8];
        end
    endtask

    task automatic run_entry(input entry_t e);
        int   wb_before;
        logic miss_seen;
        cache_bus_pkg::data_word_t got;
        wb_before   = wb_cnt;
        miss_seen   = 1'b0;
        req_valid_i = 1'b1;
        req_op_i    = e.op;
        req_addr_i  = e.addr;
        req_wstrb_i = e.strb;
        req_wdata_i = e.wdata;
        uncache_i   = e.unc;
        do @(negedge clk); while (!addr_ok_o);
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
        do begin
            @(negedge clk);
            miss_seen = miss_seen | cache_miss_o;
            if (rd_req_o) begin
                check_addr("rd_addr_o", rd_addr_o, {e.addr[31:5], 5'b00000});   // line address
            end
            if (uc_ren_o || uc_wen_o) begin
                check_addr("uc_addr_o", uc_addr_o, e.addr);
                check_bit("uc_wen_o", uc_wen_o, e.op);
            end
        end while (!data_ok_o);
        got = rdata_o;
        check_bit("cache_miss_o", miss_seen, e.miss);
        if (!e.op) check_word("rdata_o", got, shadow_word(e.addr));
        check_bit("wr_req_o", wb_cnt != wb_before, e.wb);
        if (wb_cnt - wb_before > 1) begin
            $display("more than one writeback for a single access at %h", e.addr);
            err_other++;
        end
        if (e.wb) begin
            check_addr("wr_addr_o", wb_addr, e.wb_line);
            for (int k = 0; k < 8; k++) begin
                check_word("wr_data_o", wb_data[32*k +: 32], shadow_word(e.wb_line + 32'(4*k)));
            end
        end
        if (e.op) shadow_store(e.addr, e.strb, e.wdata);
    endtask

    // stalled writeback must not overlap a line read
    always @(negedge clk) begin
        if (wr_req_o && !wr_rdy_i) check_bit("rd_req_o", rd_req_o, 1'b0);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the access table did not complete", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = 1'b0;
        req_addr_i  = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        uncache_i   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = u_line_mem.mem[i];
        end
        do @(negedge clk); while (!addr_ok_o);   // tag sweep done
        @(posedge clk);
        #1;
        for (int i = 0; i < n_entries; i++) begin
            run_entry(stim[i]);
            @(posedge clk);
            #1;
        end
        $display("errors: %0d mismatches, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/line_mem_model.sv ====
`timescale 1ns/100ps

module line_mem_model (
    input  logic                       clk,
    input  logic                       rd_req_i,
    input  cache_geom_pkg::phys_addr_t rd_addr_i,
    output logic                       rd_rdy_o,
    output logic                       ret_valid_o,
    output cache_bus_pkg::line_data_t  ret_data_o,
    input  logic                       wr_req_i,
    input  cache_geom_pkg::phys_addr_t wr_addr_i,
    input  cache_bus_pkg::line_data_t  wr_data_i,
    output logic                       wr_rdy_o,
    input  logic                       uc_ren_i,
    input  logic                       uc_wen_i,
    input  cache_geom_pkg::phys_addr_t uc_addr_i,
    input  cache_bus_pkg::data_word_t  uc_wdata_i,
    input  cache_geom_pkg::byte_strb_t uc_strb_i,
    output logic                       uc_rvalid_o,
    output cache_bus_pkg::data_word_t  uc_rdata_o,
    output logic                       uc_bvalid_o,
    output int                         wb_cnt_o,
    output cache_geom_pkg::phys_addr_t wb_addr_o,
    output cache_bus_pkg::line_data_t  wb_data_o
);

    localparam int rd_latency = 3;

    logic [7:0] mem [65536];   // low 16 address bits only
    int         seed;
    int         rd_cnt;
    int         wr_wait;
    logic       rd_seen;
    logic       wr_seen;
    logic       wr_go;
    logic       uc_seen;
    logic       uc_busy;
    logic       uc_wr;
    cache_geom_pkg::phys_addr_t rd_a;
    cache_geom_pkg::phys_addr_t wr_a;
    cache_geom_pkg::phys_addr_t uc_a;
    cache_bus_pkg::line_data_t  wr_d;
    cache_bus_pkg::data_word_t  uc_d;
    cache_geom_pkg::byte_strb_t uc_s;

    initial begin
        seed = 32'h9dcb;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'($random(seed));
        end
        rd_rdy_o    = 1'b1;
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        wr_rdy_o    = 1'b0;
        uc_rvalid_o = 1'b0;
        uc_bvalid_o = 1'b0;
        uc_rdata_o  = '0;
        wb_cnt_o    = 0;
        wb_addr_o   = '0;
        wb_data_o   = '0;
        rd_cnt      = 0;
        wr_wait     = 0;
        uc_busy     = 1'b0;
    end

    always @(negedge clk) begin
        rd_seen = rd_req_i;
        rd_a    = rd_addr_i;
        wr_go   = wr_req_i && wr_rdy_o;
        wr_seen = wr_req_i;
        wr_a    = wr_addr_i;
        wr_d    = wr_data_i;
        uc_seen = uc_ren_i || uc_wen_i;
        uc_wr   = uc_wen_i;
        uc_a    = uc_addr_i;
        uc_d    = uc_wdata_i;
        uc_s    = uc_strb_i;
        @(posedge clk);
        #1;
        if (ret_valid_o) begin
            ret_valid_o = 1'b0;
        end else if (rd_cnt > 0) begin
            rd_cnt = rd_cnt - 1;
            if (rd_cnt == 0) begin
                for (int j = 0; j < 32; j++) begin
                    ret_data_o[8*j +: 8] = mem[{rd_a[15:5], 5'(j)}];
                end
                ret_valid_o = 1'b1;
            end
        end else if (rd_seen) begin
            rd_cnt = rd_latency;
        end
        if (wr_go) begin
            for (int j = 0; j < 32; j++) begin
                mem[{wr_a[15:5], 5'(j)}] = wr_d[8*j +: 8];
            end
            wb_cnt_o  = wb_cnt_o + 1;
            wb_addr_o = wr_a;
            wb_data_o = wr_d;
            $display("writeback %h: %h", wr_a, wr_d);
            wr_rdy_o = 1'b0;
            wr_wait  = 0;
        end else if (wr_seen) begin
            wr_wait = wr_wait + 1;
            if (wr_wait == 2) wr_rdy_o = 1'b1;   // two stalled cycles first
        end
        if (uc_rvalid_o || uc_bvalid_o) begin
            uc_rvalid_o = 1'b0;
            uc_bvalid_o = 1'b0;
        end else if (uc_busy) begin
            uc_busy = 1'b0;
            for (int k = 0; k < 4; k++) begin
                if (uc_wr && uc_s[k]) mem[{uc_a[15:2], 2'(k)}] = uc_d[8*k +: 8];
                uc_rdata_o[8*k +: 8] = mem[{uc_a[15:2], 2'(k)}];
            end
            uc_bvalid_o = uc_wr;
            uc_rvalid_o = !uc_wr;
        end else if (uc_seen) begin
            uc_busy = 1'b1;
        end
    end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid_i,
    input  logic                          req_op_i,
    input  cache_geom_pkg::phys_addr_t    req_addr_i,
    input  cache_geom_pkg::byte_strb_t    req_wstrb_i,
    input  cache_bus_pkg::data_word_t     req_wdata_i,
    input  logic                          uncache_i,
    output logic                          addr_ok_o,
    output logic                          data_ok_o,
    output cache_bus_pkg::data_word_t     rdata_o,
    output logic                          cache_miss_o,
    output logic                          rd_req_o,
    output cache_geom_pkg::phys_addr_t    rd_addr_o,
    input  logic                          rd_rdy_i,
    input  logic                          ret_valid_i,
    input  cache_bus_pkg::line_data_t     ret_data_i,
    output logic                          wr_req_o,
    output cache_geom_pkg::phys_addr_t    wr_addr_o,
    output cache_bus_pkg::line_data_t     wr_data_o,
    input  logic                          wr_rdy_i,
    output logic                          uc_ren_o,
    output logic                          uc_wen_o,
    output cache_geom_pkg::phys_addr_t    uc_addr_o,
    output cache_bus_pkg::data_word_t     uc_wdata_o,
    output cache_geom_pkg::byte_strb_t    uc_strb_o,
    input  logic                          uc_rvalid_i,
    input  cache_bus_pkg::data_word_t     uc_rdata_i,
    input  logic                          uc_bvalid_i
);

    cache_geom_pkg::set_index_t  rd_index;
    cache_geom_pkg::set_index_t  wr_index;
    cache_geom_pkg::byte_strb_t [cache_geom_pkg::bank_num-1:0]
                                 way_bank_we [cache_geom_pkg::way_num];
    cache_bus_pkg::line_data_t   line_wdata;
    logic [cache_geom_pkg::way_num-1:0] tag_we;
    cache_geom_pkg::tag_t        tag_wdata;
    logic                        valid_wdata;
    cache_geom_pkg::tag_t        way_tag [cache_geom_pkg::way_num];
    logic [cache_geom_pkg::way_num-1:0] way_valid;
    cache_bus_pkg::line_data_t   way_line [cache_geom_pkg::way_num];

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .req_valid_i(req_valid_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
        .req_wstrb_i(req_wstrb_i), .req_wdata_i(req_wdata_i), .uncache_i(uncache_i),
        .addr_ok_o(addr_ok_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o),
        .cache_miss_o(cache_miss_o),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o), .rd_rdy_i(rd_rdy_i),
        .ret_valid_i(ret_valid_i), .ret_data_i(ret_data_i),
        .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o), .wr_rdy_i(wr_rdy_i),
        .uc_ren_o(uc_ren_o), .uc_wen_o(uc_wen_o), .uc_addr_o(uc_addr_o),
        .uc_wdata_o(uc_wdata_o), .uc_strb_o(uc_strb_o),
        .uc_rvalid_i(uc_rvalid_i), .uc_rdata_i(uc_rdata_i), .uc_bvalid_i(uc_bvalid_i),
        .rd_index_o(rd_index), .wr_index_o(wr_index), .way_bank_we_o(way_bank_we),
        .line_wdata_o(line_wdata), .tag_we_o(tag_we), .tag_wdata_o(tag_wdata),
        .valid_wdata_o(valid_wdata),
        .way_tag_i(way_tag), .way_valid_i(way_valid), .way_line_i(way_line)
    );

    dcache_way u_way0 (
        .clk(clk), .reset(reset), .rd_index_i(rd_index), .wr_index_i(wr_index),
        .bank_we_i(way_bank_we[0]), .bank_wdata_i(line_wdata), .tag_we_i(tag_we[0]),
        .tag_wdata_i(tag_wdata), .valid_wdata_i(valid_wdata),
        .tag_o(way_tag[0]), .valid_o(way_valid[0]), .line_o(way_line[0])
    );

    dcache_way u_way1 (
        .clk(clk), .reset(reset), .rd_index_i(rd_index), .wr_index_i(wr_index),
        .bank_we_i(way_bank_we[1]), .bank_wdata_i(line_wdata), .tag_we_i(tag_we[1]),
        .tag_wdata_i(tag_wdata), .valid_wdata_i(valid_wdata),
        .tag_o(way_tag[1]), .valid_o(way_valid[1]), .line_o(way_line[1])
    );

endmodule

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid_i,
    input  logic                                req_op_i,
    input  cache_geom_pkg::phys_addr_t          req_addr_i,
    input  cache_geom_pkg::byte_strb_t          req_wstrb_i,
    input  cache_bus_pkg::data_word_t           req_wdata_i,
    input  logic                                uncache_i,
    output logic                                addr_ok_o,
    output logic                                data_ok_o,
    output cache_bus_pkg::data_word_t           rdata_o,
    output logic                                cache_miss_o,
    output logic                                rd_req_o,
    output cache_geom_pkg::phys_addr_t          rd_addr_o,
    input  logic                                rd_rdy_i,
    input  logic                                ret_valid_i,
    input  cache_bus_pkg::line_data_t           ret_data_i,
    output logic                                wr_req_o,
    output cache_geom_pkg::phys_addr_t          wr_addr_o,
    output cache_bus_pkg::line_data_t           wr_data_o,
    input  logic                                wr_rdy_i,
    output logic                                uc_ren_o,
    output logic                                uc_wen_o,
    output cache_geom_pkg::phys_addr_t          uc_addr_o,
    output cache_bus_pkg::data_word_t           uc_wdata_o,
    output cache_geom_pkg::byte_strb_t          uc_strb_o,
    input  logic                                uc_rvalid_i,
    input  cache_bus_pkg::data_word_t           uc_rdata_i,
    input  logic                                uc_bvalid_i,
    output cache_geom_pkg::set_index_t          rd_index_o,
    output cache_geom_pkg::set_index_t          wr_index_o,
    output cache_geom_pkg::byte_strb_t [cache_geom_pkg::bank_num-1:0]
                                                way_bank_we_o [cache_geom_pkg::way_num],
    output cache_bus_pkg::line_data_t           line_wdata_o,
    output logic [cache_geom_pkg::way_num-1:0]  tag_we_o,
    output cache_geom_pkg::tag_t                tag_wdata_o,
    output logic                                valid_wdata_o,
    input  cache_geom_pkg::tag_t                way_tag_i [cache_geom_pkg::way_num],
    input  logic [cache_geom_pkg::way_num-1:0]  way_valid_i,
    input  cache_bus_pkg::line_data_t           way_line_i [cache_geom_pkg::way_num]
);

    cache_bus_pkg::ctrl_state_t state, state_nxt;

    logic                        sweep_on;
    cache_geom_pkg::set_index_t  sweep_cnt;

    logic                        req_op_q;
    cache_geom_pkg::phys_addr_t  req_addr_q;
    cache_geom_pkg::byte_strb_t  req_wstrb_q;
    cache_bus_pkg::data_word_t   req_wdata_q;

    logic                        rd_taken;
    cache_bus_pkg::line_data_t   refill_q;

    logic [cache_geom_pkg::set_num-1:0] lru;   // way to replace next
    logic [cache_geom_pkg::set_num-1:0] dirty [cache_geom_pkg::way_num];

    cache_geom_pkg::tag_t        req_tag;
    cache_geom_pkg::set_index_t  req_index;
    cache_geom_pkg::bank_sel_t   req_bank;
    logic [cache_geom_pkg::way_num-1:0] hit;
    logic                        hit_any;
    logic                        hit_way;
    logic                        victim;
    logic                        accept;
    logic                        ret_take;
    logic                        uc_done;
    cache_bus_pkg::data_word_t   wmask;
    cache_bus_pkg::line_data_t   merged_line;

    assign req_tag   = req_addr_q[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];
    assign req_index = req_addr_q[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w];
    assign req_bank  = req_addr_q[2 +: $bits(cache_geom_pkg::bank_sel_t)];

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::way_num; w++) begin
            hit[w] = way_valid_i[w] && (way_tag_i[w] == req_tag);
        end
    end

    assign hit_any = |hit;
    assign hit_way = hit[1];
    assign victim  = lru[req_index];

    assign accept   = req_valid_i && addr_ok_o;
    assign ret_take = (state == cache_bus_pkg::askmem) && ret_valid_i && (rd_taken || rd_rdy_i);
    assign uc_done  = req_op_q ? uc_bvalid_i : uc_rvalid_i;

    assign wmask = {{8{req_wstrb_q[3]}}, {8{req_wstrb_q[2]}},
                    {8{req_wstrb_q[1]}}, {8{req_wstrb_q[0]}}};

    // refill line with a pending store folded in
    always_comb begin
        merged_line = refill_q;
        if (req_op_q) begin
            merged_line[32*req_bank +: 32] = (req_wdata_q & wmask) |
                                             (refill_q[32*req_bank +: 32] & ~wmask);
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            cache_bus_pkg::idle: begin
                if (accept) begin
                    state_nxt = uncache_i ? cache_bus_pkg::uncache : cache_bus_pkg::lookup;
                end
            end
            cache_bus_pkg::lookup: begin
                if (hit_any) begin
                    state_nxt = cache_bus_pkg::idle;
                end else if (dirty[victim][req_index]) begin
                    state_nxt = cache_bus_pkg::wback;
                end else begin
                    state_nxt = cache_bus_pkg::askmem;
                end
            end
            cache_bus_pkg::wback:   if (wr_rdy_i) state_nxt = cache_bus_pkg::askmem;
            cache_bus_pkg::askmem:  if (ret_take) state_nxt = cache_bus_pkg::refill;
            cache_bus_pkg::refill:  state_nxt = cache_bus_pkg::idle;
            cache_bus_pkg::uncache: if (uc_done) state_nxt = cache_bus_pkg::idle;
            default:                state_nxt = cache_bus_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cache_bus_pkg::idle;
            sweep_on  <= 1'b1;
            sweep_cnt <= '0;
            rd_taken  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (sweep_on) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (&sweep_cnt) sweep_on <= 1'b0;   // last set cleared
            end
            if (state != cache_bus_pkg::askmem) begin
                rd_taken <= 1'b0;
            end else if (rd_rdy_i) begin
                rd_taken <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru   <= '0;
            dirty <= '{default: '0};
        end else if (state == cache_bus_pkg::lookup && hit_any) begin
            lru[req_index] <= ~hit_way;
            if (req_op_q) dirty[hit_way][req_index] <= 1'b1;
        end else if (state == cache_bus_pkg::refill) begin
            lru[req_index]            <= ~victim;
            dirty[victim][req_index]  <= req_op_q;   // store miss leaves it dirty
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op_q    <= req_op_i;
            req_addr_q  <= req_addr_i;
            req_wstrb_q <= req_wstrb_i;
            req_wdata_q <= req_wdata_i;
        end
        if (ret_take) refill_q <= ret_data_i;
    end

    assign addr_ok_o    = (state == cache_bus_pkg::idle) && !sweep_on;
    assign cache_miss_o = (state == cache_bus_pkg::lookup) && !hit_any;
    assign data_ok_o    = ((state == cache_bus_pkg::lookup) && hit_any) ||
                          (state == cache_bus_pkg::refill) ||
                          ((state == cache_bus_pkg::uncache) && uc_done);

    always_comb begin
        unique case (state)
            cache_bus_pkg::uncache: rdata_o = uc_rdata_i;
            cache_bus_pkg::refill:  rdata_o = merged_line[32*req_bank +: 32];
            default:                rdata_o = way_line_i[hit_way][32*req_bank +: 32];
        endcase
    end

    assign rd_req_o  = (state == cache_bus_pkg::askmem) && !ret_valid_i;
    assign rd_addr_o = {req_addr_q[cache_geom_pkg::addr_w-1:cache_geom_pkg::offset_w],
                        {cache_geom_pkg::offset_w{1'b0}}};

    // victim line stays on the read port while the index is held
    assign wr_req_o  = (state == cache_bus_pkg::wback);
    assign wr_addr_o = {way_tag_i[victim], req_index, {cache_geom_pkg::offset_w{1'b0}}};
    assign wr_data_o = way_line_i[victim];

    assign uc_ren_o   = (state == cache_bus_pkg::uncache) && !req_op_q;
    assign uc_wen_o   = (state == cache_bus_pkg::uncache) && req_op_q;
    assign uc_addr_o  = req_addr_q;
    assign uc_wdata_o = req_wdata_q;
    assign uc_strb_o  = req_wstrb_q;

    assign rd_index_o = (state == cache_bus_pkg::idle) ?
                        req_addr_i[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w] :
                        req_index;
    assign wr_index_o    = sweep_on ? sweep_cnt : req_index;
    assign tag_wdata_o   = req_tag;
    assign valid_wdata_o = !sweep_on;
    assign line_wdata_o  = (state == cache_bus_pkg::refill) ? merged_line :
                           {cache_geom_pkg::bank_num{req_wdata_q}};

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::way_num; w++) begin
            tag_we_o[w] = sweep_on || ((state == cache_bus_pkg::refill) && (victim == w));
            for (int b = 0; b < cache_geom_pkg::bank_num; b++) begin
                way_bank_we_o[w][b] = '0;
                if ((state == cache_bus_pkg::refill) && (victim == w)) begin
                    way_bank_we_o[w][b] = 4'hf;   // whole line
                end else if ((state == cache_bus_pkg::lookup) && hit[w] && req_op_q &&
                             (req_bank == b)) begin
                    way_bank_we_o[w][b] = req_wstrb_q;
                end
            end
        end
    end

endmodule

// ==== logic/dcache_way.sv ====
`timescale 1ns/100ps

module dcache_way (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  cache_geom_pkg::set_index_t                           rd_index_i,
    input  cache_geom_pkg::set_index_t                           wr_index_i,
    input  cache_geom_pkg::byte_strb_t [cache_geom_pkg::bank_num-1:0] bank_we_i,
    input  cache_bus_pkg::line_data_t                            bank_wdata_i,
    input  logic                                                 tag_we_i,
    input  cache_geom_pkg::tag_t                                 tag_wdata_i,
    input  logic                                                 valid_wdata_i,
    output cache_geom_pkg::tag_t                                 tag_o,
    output logic                                                 valid_o,
    output cache_bus_pkg::line_data_t                            line_o
);

    cache_geom_pkg::tag_t tag_mem [cache_geom_pkg::set_num];
    logic [cache_geom_pkg::set_num-1:0] valid_mem;   // cleared by the controller sweep

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[wr_index_i]   <= tag_wdata_i;
            valid_mem[wr_index_i] <= valid_wdata_i;
        end
        tag_o <= tag_mem[rd_index_i];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_mem[rd_index_i];
        end
    end

    for (genvar b = 0; b < cache_geom_pkg::bank_num; b++) begin : g_bank
        cache_bus_pkg::data_word_t mem [cache_geom_pkg::set_num];
        cache_bus_pkg::data_word_t rd_q;

        always_ff @(posedge clk) begin
            for (int k = 0; k < 4; k++) begin
                if (bank_we_i[b][k]) begin
                    mem[wr_index_i][8*k +: 8] <= bank_wdata_i[32*b + 8*k +: 8];
                end
            end
            rd_q <= mem[rd_index_i];   // block ram style read
        end

        assign line_o[32*b +: 32] = rd_q;
    end

endmodule

// ==== logic/cache_bus_pkg.sv ====
package cache_bus_pkg;

    localparam int word_w = 32;
    localparam int line_w = 256;        // eight words

    typedef logic [word_w-1:0] data_word_t;

    // word 0 sits in the low 32 bits
    typedef logic [line_w-1:0] line_data_t;

    typedef enum logic [2:0] {
        idle,       // waiting for a request
        lookup,     // tag compare, hit completes here
        wback,      // dirty victim out to memory
        askmem,     // line read pending
        refill,     // line written into the victim way
        uncache     // word port access
    } ctrl_state_t;

endpackage

// ==== logic/cache_geom_pkg.sv ====
package cache_geom_pkg;

    localparam int addr_w   = 32;
    localparam int tag_w    = 20;
    localparam int index_w  = 7;
    localparam int offset_w = 5;        // 32-byte line
    localparam int bank_num = 8;        // words per line
    localparam int set_num  = 128;
    localparam int way_num  = 2;

    // byte address, tag in [31:12], index in [11:5], offset in [4:0]
    typedef logic [addr_w-1:0] phys_addr_t;

    typedef logic [tag_w-1:0] tag_t;

    typedef logic [index_w-1:0] set_index_t;

    // word within a line, address bits [4:2]
    typedef logic [2:0] bank_sel_t;

    typedef logic [3:0] byte_strb_t;    // one bit per byte lane

endpackage
